//--- dv/processor_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor_assert
// reset, writeback and stall properties of the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module processor_assert
    import pipe_pkg::*;
(
    input wire logic             clock_i,
    input wire logic             reset_i,
    input wire logic             rf_write_en_i,
    input wire logic [REG_W-1:0] rf_write_reg_i,
    input wire logic             dmem_wren_i,
    input wire logic [XLEN-1:0]  imem_addr_i,
    input wire logic             stall_i,
    input wire logic             redirect_valid_i
);

    int unsigned fail_count = 0;  // failed properties so far

    // registers clear on the first reset edge
    a_no_write_in_reset: assert property (@(posedge clock_i)
        reset_i && $past(reset_i) |-> !rf_write_en_i && !dmem_wren_i)
        else begin
            fail_count++;
            $error("write enable high while reset is held");
        end

    a_no_r0_write: assert property (@(posedge clock_i)
        rf_write_en_i |-> rf_write_reg_i != '0)
        else begin
            fail_count++;
            $error("register file write to register 0");
        end

    a_pc_held: assert property (@(posedge clock_i) disable iff (reset_i)
        stall_i && !redirect_valid_i |=> $stable(imem_addr_i))
        else begin
            fail_count++;
            $error("fetch address moved during a load-use stall");
        end

endmodule

`default_nettype wire

//--- dv/isa_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// isa_model
// in-order reference run of a program and the builders
// for the directed and random test programs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
} store_t;

wb_t    exp_wb[$];  // expected register writes in program order
store_t exp_st[$];  // expected stores
int     prog_len;

// depends on every address bit
function automatic logic [XLEN-1:0] dmem_fill(int unsigned addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
endfunction

function automatic logic [XLEN-1:0] enc_r(int fn, int rd, int rs, int rt, int sh);
    return {op_rtype, 5'(rd), 5'(rs), 5'(rt), 5'(sh), 5'(fn), 2'b00};
endfunction

function automatic logic [XLEN-1:0] enc_i(opcode_e op, int rd, int rs, int imm);
    return {op, 5'(rd), 5'(rs), IMM_W'(imm)};
endfunction

function automatic logic [XLEN-1:0] enc_j(int target);
    return {op_j, TGT_W'(target)};
endfunction

function automatic void start_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = '0;  // add r0, r0, r0
    end
    prog_len = 0;
endfunction

function automatic void emit(logic [XLEN-1:0] word);
    imem[prog_len] = word;
    prog_len++;
endfunction

function automatic logic [REG_W-1:0] random_reg();
    return REG_W'($urandom_range(7, 0));  // few registers, dense dependencies
endfunction

// runs to the final self-jump, returns the executed instruction count
function automatic int run_model();
    logic [XLEN-1:0]  regs [32];
    logic [XLEN-1:0]  mem [DMEM_WORDS];
    logic [XLEN-1:0]  ins;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  imm;
    logic [XLEN-1:0]  ea;
    logic [XLEN-1:0]  res;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic             wr;
    int               count;
    exp_wb.delete();
    exp_st.delete();
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] = dmem_fill(i);
    end
    pc = '0;
    count = 0;
    while (count < IMEM_WORDS * 8) begin
        ins = imem[pc[IDX_W-1:0]];
        count++;
        if (ins == enc_j(pc)) begin
            break;
        end
        rd  = ins[26:22];
        rs  = ins[21:17];
        rt  = ins[16:12];
        imm = {{(XLEN-IMM_W){ins[IMM_W-1]}}, ins[IMM_W-1:0]};
        ea  = regs[rs] + imm;
        wr  = 1'b0;
        res = '0;
        pc  = pc + 1;
        case (ins[31:27])
            op_rtype: begin
                wr = 1'b1;
                case (ins[6:2])
                    alu_add: res = regs[rs] + regs[rt];
                    alu_sub: res = regs[rs] - regs[rt];
                    alu_and: res = regs[rs] & regs[rt];
                    alu_or:  res = regs[rs] | regs[rt];
                    alu_sll: res = regs[rs] << ins[11:7];
                    alu_sra: res = $signed(regs[rs]) >>> ins[11:7];
                    default: res = '0;
                endcase
            end
            op_addi: begin
                wr  = 1'b1;
                res = ea;
            end
            op_lw: begin
                wr  = 1'b1;
                res = mem[ea[IDX_W-1:0]];
            end
            op_sw: begin
                mem[ea[IDX_W-1:0]] = regs[rd];
                exp_st.push_back('{addr: ea, data: regs[rd]});
            end
            op_j:    pc = {{(XLEN-TGT_W){1'b0}}, ins[TGT_W-1:0]};
            op_bne:  pc = (regs[rd] != regs[rs]) ? pc + imm : pc;
            op_blt:  pc = ($signed(regs[rd]) < $signed(regs[rs])) ? pc + imm : pc;
            default: wr = 1'b0;  // retires as a no-op
        endcase
        if (wr && rd != '0) begin
            regs[rd] = res;
            exp_wb.push_back('{en: 1'b1, idx: rd, data: res});
        end
    end
    return count;
endfunction

function automatic void build_alu_chain();
    start_program();
    emit(enc_i(op_addi, 1, 0, 5));
    emit(enc_i(op_addi, 2, 1, -3));
    emit(enc_r(alu_add, 3, 1, 2, 0));
    emit(enc_r(alu_sub, 4, 3, 1, 0));
    emit(enc_r(alu_and, 5, 4, 3, 0));
    emit(enc_r(alu_or, 6, 5, 1, 0));
    emit(enc_r(alu_sll, 7, 6, 0, 3));
    emit(enc_i(op_addi, 8, 0, -100));
    emit(enc_r(alu_sra, 9, 8, 0, 2));
    emit(enc_r(alu_sub, 10, 2, 7, 0));  // r7 from three back, decode bypass
    emit(enc_r(7, 11, 1, 2, 0));        // unused ALU op gives zero
    emit(enc_r(alu_add, 0, 1, 2, 0));   // write to r0 dropped
    emit(enc_r(alu_add, 12, 0, 9, 0));
    emit(enc_j(prog_len));
endfunction

function automatic void build_load_store();
    start_program();
    emit(enc_i(op_addi, 1, 0, 21));
    emit(enc_i(op_addi, 2, 1, 100));
    emit(enc_i(op_sw, 2, 0, 4));        // store of a fresh result
    emit(enc_i(op_lw, 3, 0, 4));
    emit(enc_r(alu_add, 4, 3, 1, 0));   // load-use
    emit(enc_i(op_sw, 4, 1, 5));
    emit(enc_i(op_lw, 5, 0, 26));
    emit(enc_i(op_sw, 5, 0, 7));        // load feeding store data
    emit(enc_i(op_lw, 6, 0, 9));
    emit(enc_i(op_addi, 7, 6, 1));
    emit(enc_i(op_lw, 0, 0, 3));
    emit(enc_r(alu_add, 8, 0, 6, 0));
    emit(enc_j(prog_len));
endfunction

function automatic void build_branches();
    start_program();
    emit(enc_i(op_addi, 1, 0, 3));
    emit(enc_i(op_addi, 2, 0, 3));
    emit(enc_i(op_bne, 1, 2, 5));       // not taken
    emit(enc_i(op_addi, 3, 0, 7));
    emit(enc_i(op_blt, 3, 1, 5));       // not taken
    emit(enc_i(op_blt, 1, 3, 2));       // taken to 8
    emit(enc_i(op_addi, 4, 0, 1));
    emit(enc_i(op_addi, 5, 0, 1));
    emit(enc_i(op_bne, 1, 3, 2));       // taken to 11
    emit(enc_i(op_addi, 6, 0, 1));
    emit(enc_i(op_addi, 7, 0, 1));
    emit(enc_j(14));
    emit(enc_i(op_addi, 8, 0, 1));
    emit(enc_i(op_addi, 9, 0, 1));
    emit(enc_i(op_addi, 1, 1, -1));     // loop three times
    emit(enc_i(op_bne, 1, 0, -2));
    emit(enc_i(op_addi, 11, 11, 1));
    emit(enc_i(op_addi, 12, 1, 9));
    emit(enc_i(op_addi, 10, 0, -1));
    emit(enc_i(op_blt, 10, 1, 1));      // negative against zero, taken
    emit(enc_i(op_addi, 13, 0, 1));
    emit(enc_j(prog_len));
endfunction

function automatic void build_random(int count);
    start_program();
    for (int i = 0; i < count; i++) begin
        case ($urandom_range(3, 0))
            0: emit(enc_r(int'($urandom_range(5, 0)), random_reg(), random_reg(),
                          random_reg(), int'($urandom_range(31, 0))));
            1: emit(enc_i(op_addi, random_reg(), random_reg(),
                          int'($urandom_range(4095, 0)) - 2048));
            2: emit(enc_i(op_lw, random_reg(), 0, int'($urandom_range(63, 0))));
            default: emit(enc_i(op_sw, random_reg(), 0, int'($urandom_range(63, 0))));
        endcase
    end
    emit(enc_j(prog_len));
endfunction

`endif

//--- dv/processor_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor_tb
// memory and register-file models around the core, programs
// checked write by write against the ISA model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module processor_tb
    import pipe_pkg::*;
();

    localparam int IDX_W        = 8;
    localparam int IMEM_WORDS   = 1 << IDX_W;
    localparam int DMEM_WORDS   = 1 << IDX_W;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 6;   // pipeline depth plus margin

    logic             clock;
    logic             reset;
    logic [XLEN-1:0]  imem_addr;
    logic [XLEN-1:0]  imem_data;
    logic [XLEN-1:0]  dmem_addr;
    logic [XLEN-1:0]  dmem_wdata;
    logic             dmem_wren;
    logic [XLEN-1:0]  dmem_rdata;
    logic             rf_write_en;
    logic [REG_W-1:0] rf_write_reg;
    logic [XLEN-1:0]  rf_write_data;
    logic [REG_W-1:0] rf_reg_a;
    logic [REG_W-1:0] rf_reg_b;
    logic [XLEN-1:0]  rf_data_a;
    logic [XLEN-1:0]  rf_data_b;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [XLEN-1:0] rf   [32];

    `include "isa_model.svh"

    tb_clock_gen u_clock (
        .clock_o (clock)
    );

    processor UUT (
        .clock_i          (clock),
        .reset_i          (reset),
        .imem_addr_o      (imem_addr),
        .imem_data_i      (imem_data),
        .dmem_addr_o      (dmem_addr),
        .dmem_wdata_o     (dmem_wdata),
        .dmem_wren_o      (dmem_wren),
        .dmem_rdata_i     (dmem_rdata),
        .rf_write_en_o    (rf_write_en),
        .rf_write_reg_o   (rf_write_reg),
        .rf_write_data_o  (rf_write_data),
        .rf_read_reg_a_o  (rf_reg_a),
        .rf_read_reg_b_o  (rf_reg_b),
        .rf_read_data_a_i (rf_data_a),
        .rf_read_data_b_i (rf_data_b)
    );

    bind processor processor_assert u_assert (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .rf_write_en_i    (rf_write_en_o),
        .rf_write_reg_i   (rf_write_reg_o),
        .dmem_wren_i      (dmem_wren_o),
        .imem_addr_i      (imem_addr_o),
        .stall_i          (stall),
        .redirect_valid_i (redirect.valid)
    );

    assign imem_data  = imem[imem_addr[IDX_W-1:0]];
    assign dmem_rdata = dmem[dmem_addr[IDX_W-1:0]];
    assign rf_data_a  = rf[rf_reg_a];
    assign rf_data_b  = rf[rf_reg_b];

    // written on the rising edge, same-cycle reads see the old value
    always @(posedge clock) begin
        if (dmem_wren) begin
            dmem[dmem_addr[IDX_W-1:0]] <= dmem_wdata;
        end
        if (rf_write_en) begin
            rf[rf_write_reg] <= rf_write_data;
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_wb(wb_t got, wb_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: rf_write_reg_o/rf_write_data_o got r%0d = %h, %s",
                     $time, got.idx, got.data, $sformatf("expected r%0d = %h", exp.idx, exp.data));
            abort_run();
        end
    endtask

    task automatic compare_store(store_t got, store_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: dmem_addr_o/dmem_wdata_o got [%h] = %h, %s",
                     $time, got.addr, got.data, $sformatf("expected [%h] = %h", exp.addr, exp.data));
            abort_run();
        end
    endtask

    task automatic compare_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_models();
        for (int i = 0; i < 32; i++) begin
            rf[i] <= '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= dmem_fill(i);
        end
    endtask

    // outputs come from pipeline registers and are settled at the falling edge
    always @(negedge clock) begin
        wb_t    got_wb;
        store_t got_st;
        got_wb = '{en: 1'b1, idx: rf_write_reg, data: rf_write_data};
        got_st = '{addr: dmem_addr, data: dmem_wdata};
        if (UUT.u_assert.fail_count != 0) begin
            $display("An assertion on the core failed before %0t ns", $time);
            abort_run();
        end
        if (rf_write_en && (reset || exp_wb.size() == 0)) begin
            $display("Unexpected register write to r%0d at %0t ns", rf_write_reg, $time);
            abort_run();
        end else if (rf_write_en) begin
            compare_wb(got_wb, exp_wb.pop_front());
        end
        if (dmem_wren && (reset || exp_st.size() == 0)) begin
            $display("Unexpected store to address %h at %0t ns", dmem_addr, $time);
            abort_run();
        end else if (dmem_wren) begin
            compare_store(got_st, exp_st.pop_front());
        end
    end

    task automatic run_program(int which, string name);
        int executed;
        int limit;
        int cycles;
        @(negedge clock);
        reset = 1'b1;
        load_models();
        case (which)
            0:       build_alu_chain();
            1:       build_load_store();
            2:       build_branches();
            default: build_random(200);
        endcase
        executed = run_model();
        limit    = RESET_CYCLES + 3 * executed + 20;
        cycles   = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        reset = 1'b0;
        compare_word("imem_addr_o", imem_addr, '0);
        if (rf_write_en || dmem_wren) begin
            $display("Write enable high in the first cycle after reset at %0t ns", $time);
            abort_run();
        end
        while (exp_wb.size() != 0 || exp_st.size() != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout in %s program: %0d writes and %0d stores missing after %0d cycles",
                         name, exp_wb.size(), exp_st.size(), cycles);
                abort_run();
            end
        end
        repeat (DRAIN_CYCLES) @(negedge clock);  // catch writes past the end
        $display("%s program done, %0d instructions in %0d cycles", name, executed, cycles);
    endtask

    initial begin
        void'($urandom(32'h19a));
        reset = 1'b1;
        start_program();
        load_models();
        run_program(0, "alu chain");
        run_program(1, "load store");
        run_program(2, "branch");
        run_program(3, "random");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_clock_gen
// free-running 100 ns testbench clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clock_o
);

    initial begin
        clock_o = 1'b0;
        forever #50 clock_o = ~clock_o;  // half period
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu
// add, sub, and, or and shifts, plus branch compare flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module alu
    import pipe_pkg::*;
(
    input  wire logic [XLEN-1:0]  a_i,
    input  wire logic [XLEN-1:0]  b_i,
    input  wire alu_op_e          op_i,
    input  wire logic [REG_W-1:0] shamt_i,
    output logic [XLEN-1:0]       result_o,
    output logic                  not_equal_o,
    output logic                  less_than_o
);

    always_comb begin
        case (op_i)
            alu_add: result_o = a_i + b_i;
            alu_sub: result_o = a_i - b_i;
            alu_and: result_o = a_i & b_i;
            alu_or:  result_o = a_i | b_i;
            alu_sll: result_o = a_i << shamt_i;
            alu_sra: result_o = $signed(a_i) >>> shamt_i;
            default: result_o = '0;  // unused op codes
        endcase
    end

    assign not_equal_o = (a_i != b_i);
    assign less_than_o = ($signed(a_i) < $signed(b_i));

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode_stage
// field split, register reads with writeback bypass,
// load-use detection and decode/execute register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import pipe_pkg::*;
(
    input  wire logic            clock_i,
    input  wire logic            reset_i,
    input  wire fd_reg_t         fd_i,
    input  wire redirect_t       redirect_i,
    input  wire wb_t             wb_i,
    input  wire logic [XLEN-1:0] rf_read_data_a_i,
    input  wire logic [XLEN-1:0] rf_read_data_b_i,
    output logic [REG_W-1:0]     rf_read_reg_a_o,
    output logic [REG_W-1:0]     rf_read_reg_b_o,
    output logic                 stall_o,
    output dx_reg_t              dx_o
);

    opcode_e          opcode;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] reg_b;
    logic [XLEN-1:0]  val_a;
    logic [XLEN-1:0]  val_b;
    logic             reads_a;
    logic             reads_b;
    dx_reg_t          dx_d;
    dx_reg_t          dx_q;

    assign opcode = opcode_e'(fd_i.instr[FLD_OPC +: OPC_W]);
    assign rd     = fd_i.instr[FLD_RD +: REG_W];
    assign rs     = fd_i.instr[FLD_RS +: REG_W];
    assign rt     = fd_i.instr[FLD_RT +: REG_W];
    assign reg_b  = (opcode == op_rtype) ? rt : rd;  // sw and branches read rd

    assign rf_read_reg_a_o = rs;
    assign rf_read_reg_b_o = reg_b;

    // register file returns the old value during its own write
    assign val_a = (wb_i.en && wb_i.idx == rs && rs != '0) ? wb_i.data : rf_read_data_a_i;
    assign val_b = (wb_i.en && wb_i.idx == reg_b && reg_b != '0) ? wb_i.data
                                                                  : rf_read_data_b_i;

    assign reads_a = opcode inside {op_rtype, op_addi, op_sw, op_lw, op_bne, op_blt};
    assign reads_b = opcode inside {op_rtype, op_sw, op_bne, op_blt};

    // load still in execute, its data shows up one cycle too late
    assign stall_o = fd_i.valid && dx_q.valid && dx_q.opcode == op_lw && dx_q.rd != '0
                     && ((reads_a && rs == dx_q.rd) || (reads_b && reg_b == dx_q.rd));

    always_comb begin
        dx_d.valid  = fd_i.valid && !stall_o && !redirect_i.valid;
        dx_d.pc     = fd_i.pc;
        dx_d.opcode = opcode;
        dx_d.alu_op = alu_op_e'(fd_i.instr[FLD_ALUOP +: 5]);
        dx_d.rd     = rd;
        dx_d.rs     = rs;
        dx_d.rt     = rt;
        dx_d.shamt  = fd_i.instr[FLD_SHAMT +: REG_W];
        dx_d.imm    = {{(XLEN-IMM_W){fd_i.instr[IMM_W-1]}}, fd_i.instr[IMM_W-1:0]};
        dx_d.target = {{(XLEN-TGT_W){1'b0}}, fd_i.instr[TGT_W-1:0]};
        dx_d.a      = val_a;
        dx_d.b      = val_b;
    end

    always_ff @(posedge clock_i) begin
        dx_q <= dx_d;
        if (reset_i) begin
            dx_q.valid <= 1'b0;
        end
    end

    assign dx_o = dx_q;

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute_stage
// operand bypass, ALU, branch resolution and the
// execute/memory register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import pipe_pkg::*;
(
    input  wire logic    clock_i,
    input  wire logic    reset_i,
    input  wire dx_reg_t dx_i,
    input  wire wb_t     wb_i,
    output xm_reg_t      xm_o,
    output redirect_t    redirect_o
);

    logic [REG_W-1:0] reg_b;
    logic             xm_fwd_ok;
    logic [XLEN-1:0]  fwd_a;
    logic [XLEN-1:0]  fwd_b;
    logic             is_branch;
    logic             use_imm;
    logic [XLEN-1:0]  alu_a;
    logic [XLEN-1:0]  alu_b;
    alu_op_e          alu_op;
    logic [XLEN-1:0]  alu_result;
    logic             not_equal;
    logic             less_than;
    logic             taken;
    xm_reg_t          xm_q;

    assign reg_b = (dx_i.opcode == op_rtype) ? dx_i.rt : dx_i.rd;

    // a load in memory never meets a consumer here, decode stalled it
    assign xm_fwd_ok = xm_q.valid && (xm_q.opcode inside {op_rtype, op_addi});

    always_comb begin
        fwd_a = dx_i.a;
        if (xm_fwd_ok && xm_q.rd == dx_i.rs && dx_i.rs != '0) begin
            fwd_a = xm_q.result;
        end else if (wb_i.en && wb_i.idx == dx_i.rs && dx_i.rs != '0) begin
            fwd_a = wb_i.data;
        end
    end

    always_comb begin
        fwd_b = dx_i.b;
        if (xm_fwd_ok && xm_q.rd == reg_b && reg_b != '0) begin
            fwd_b = xm_q.result;
        end else if (wb_i.en && wb_i.idx == reg_b && reg_b != '0) begin
            fwd_b = wb_i.data;
        end
    end

    assign is_branch = dx_i.opcode inside {op_bne, op_blt};
    assign use_imm   = dx_i.opcode inside {op_addi, op_lw, op_sw};

    // branches compare rd against rs
    assign alu_a  = is_branch ? fwd_b : fwd_a;
    assign alu_b  = is_branch ? fwd_a : (use_imm ? dx_i.imm : fwd_b);
    assign alu_op = (dx_i.opcode == op_rtype) ? dx_i.alu_op : alu_add;

    alu u_alu (
        .a_i         (alu_a),
        .b_i         (alu_b),
        .op_i        (alu_op),
        .shamt_i     (dx_i.shamt),
        .result_o    (alu_result),
        .not_equal_o (not_equal),
        .less_than_o (less_than)
    );

    assign taken = (dx_i.opcode == op_j)
                 || (dx_i.opcode == op_bne && not_equal)
                 || (dx_i.opcode == op_blt && less_than);

    assign redirect_o.valid = dx_i.valid && taken;
    assign redirect_o.pc    = (dx_i.opcode == op_j) ? dx_i.target
                                                    : dx_i.pc + 1'b1 + dx_i.imm;

    always_ff @(posedge clock_i) begin
        xm_q.valid      <= dx_i.valid;
        xm_q.opcode     <= dx_i.opcode;
        xm_q.rd         <= dx_i.rd;
        xm_q.result     <= alu_result;
        xm_q.store_data <= fwd_b;  // sw stores rd
        if (reset_i) begin
            xm_q.valid <= 1'b0;
        end
    end

    assign xm_o = xm_q;

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_stage
// program counter and fetch/decode register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import pipe_pkg::*;
(
    input  wire logic            clock_i,
    input  wire logic            reset_i,
    input  wire logic            stall_i,
    input  wire redirect_t       redirect_i,
    input  wire logic [XLEN-1:0] imem_data_i,
    output logic [XLEN-1:0]      imem_addr_o,
    output fd_reg_t              fd_o
);

    logic [XLEN-1:0] pc_q;
    fd_reg_t         fd_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.pc;  // taken branch or jump
        end else if (!stall_i) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            fd_q <= '{valid: 1'b1, pc: pc_q, instr: imem_data_i};
        end
        if (reset_i || redirect_i.valid) begin
            fd_q.valid <= 1'b0;  // wrong-path slot
        end
    end

    assign imem_addr_o = pc_q;
    assign fd_o        = fd_q;

endmodule

`default_nettype wire

//--- hdl/mem_wb_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mem_wb_stage
// data memory access and the writeback register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage
    import pipe_pkg::*;
(
    input  wire logic            clock_i,
    input  wire logic            reset_i,
    input  wire xm_reg_t         xm_i,
    input  wire logic [XLEN-1:0] dmem_rdata_i,
    output logic [XLEN-1:0]      dmem_addr_o,
    output logic [XLEN-1:0]      dmem_wdata_o,
    output logic                 dmem_wren_o,
    output wb_t                  wb_o
);

    logic writes_rd;
    wb_t  wb_q;

    assign dmem_addr_o  = xm_i.result;  // rs plus immediate
    assign dmem_wdata_o = xm_i.store_data;
    assign dmem_wren_o  = xm_i.valid && xm_i.opcode == op_sw;

    // register 0 stays zero
    assign writes_rd = xm_i.valid && xm_i.rd != '0
                       && (xm_i.opcode inside {op_rtype, op_addi, op_lw});

    always_ff @(posedge clock_i) begin
        wb_q.en   <= writes_rd;
        wb_q.idx  <= xm_i.rd;
        wb_q.data <= (xm_i.opcode == op_lw) ? dmem_rdata_i : xm_i.result;
        if (reset_i) begin
            wb_q.en <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

//--- hdl/pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipe_pkg
// widths, instruction fields, opcode and ALU enums and the
// pipeline register bundles of the five-stage core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pipe_pkg;

    localparam int XLEN  = 32;  // data and address width
    localparam int REG_W = 5;   // register index width
    localparam int IMM_W = 17;  // I-type immediate width
    localparam int OPC_W = 5;
    localparam int TGT_W = 27;  // jump target width

    // low bit of each instruction field
    localparam int FLD_OPC   = 27;
    localparam int FLD_RD    = 22;
    localparam int FLD_RS    = 17;
    localparam int FLD_RT    = 12;
    localparam int FLD_SHAMT = 7;
    localparam int FLD_ALUOP = 2;

    typedef enum logic [OPC_W-1:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_addi  = 5'b00101,
        op_blt   = 5'b00110,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fd_reg_t;

    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        opcode_e          opcode;
        alu_op_e          alu_op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] shamt;
        logic [XLEN-1:0]  imm;     // sign extended
        logic [XLEN-1:0]  target;  // zero extended
        logic [XLEN-1:0]  a;       // rs value
        logic [XLEN-1:0]  b;       // rt for R-type, rd otherwise
    } dx_reg_t;

    typedef struct packed {
        logic             valid;
        opcode_e          opcode;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  result;
        logic [XLEN-1:0]  store_data;
    } xm_reg_t;

    typedef struct packed {
        logic             en;
        logic [REG_W-1:0] idx;
        logic [XLEN-1:0]  data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

//--- hdl/processor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor
// five-stage pipelined core, memories and register
// file sit outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module processor
    import pipe_pkg::*;
(
    input  wire logic             clock_i,
    input  wire logic             reset_i,
    output logic [XLEN-1:0]       imem_addr_o,
    input  wire logic [XLEN-1:0]  imem_data_i,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic                  dmem_wren_o,
    input  wire logic [XLEN-1:0]  dmem_rdata_i,
    output logic                  rf_write_en_o,
    output logic [REG_W-1:0]      rf_write_reg_o,
    output logic [XLEN-1:0]       rf_write_data_o,
    output logic [REG_W-1:0]      rf_read_reg_a_o,
    output logic [REG_W-1:0]      rf_read_reg_b_o,
    input  wire logic [XLEN-1:0]  rf_read_data_a_i,
    input  wire logic [XLEN-1:0]  rf_read_data_b_i
);

    fd_reg_t   fd;
    dx_reg_t   dx;
    xm_reg_t   xm;
    wb_t       wb;
    redirect_t redirect;
    logic      stall;

    fetch_stage u_fetch (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .fd_o        (fd)
    );

    decode_stage u_decode (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .fd_i             (fd),
        .redirect_i       (redirect),
        .wb_i             (wb),
        .rf_read_data_a_i (rf_read_data_a_i),
        .rf_read_data_b_i (rf_read_data_b_i),
        .rf_read_reg_a_o  (rf_read_reg_a_o),
        .rf_read_reg_b_o  (rf_read_reg_b_o),
        .stall_o          (stall),
        .dx_o             (dx)
    );

    execute_stage u_execute (
        .clock_i    (clock_i),
        .reset_i    (reset_i),
        .dx_i       (dx),
        .wb_i       (wb),
        .xm_o       (xm),
        .redirect_o (redirect)
    );

    mem_wb_stage u_mem_wb (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .xm_i         (xm),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_wren_o  (dmem_wren_o),
        .wb_o         (wb)
    );

    assign rf_write_en_o   = wb.en;
    assign rf_write_reg_o  = wb.idx;
    assign rf_write_data_o = wb.data;

endmodule

`default_nettype wire

//--- processor.f
+incdir+dv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/processor.sv
dv/tb_clock_gen.sv
dv/processor_assert.sv
dv/processor_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module processor_tb \
    -f processor.f -o processor_sim \
    && ./obj_dir/processor_sim \
    || { echo "simulation ended with an error"; exit 1; }
